// File: verilog/rv_isa_pkg.sv
package rv_isa_pkg;

    // --------------------
    // Major opcodes
    // --------------------
    typedef enum logic [6:0] {
        OP     = 7'b0110011,   // Register-register ALU
        OP_IMM = 7'b0010011,   // Register-immediate ALU
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    // --------------------
    // funct3 values
    // --------------------
    localparam logic [2:0] F3_ADD_SUB = 3'b000;   // Also beq, lw and sw use 010/000
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // --------------------
    // Field positions
    // --------------------
    // Bit numbers inside the 32-bit instruction word
    localparam int OPCODE_MSB = 6;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int BIT30_POS  = 30;   // Selects sub and sra

endpackage

// File: verilog/core_pkg.sv
package core_pkg;

    // --------------------
    // Datapath sizes
    // --------------------
    localparam int XLEN           = 32;   // Register and ALU width
    localparam int ADDR_WIDTH     = 10;   // Both memory address ports
    localparam int REG_ADDR_WIDTH = 5;    // Index into the 32 registers

    // --------------------
    // ALU operations
    // --------------------
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLL,
        SRL,
        SRA
    } alu_op_e;

    // Coarse class from the main decoder, refined by alu_control
    typedef enum logic [1:0] {
        MEM_ADD,      // Address arithmetic and upper immediates
        BRANCH_SUB,   // Compare for beq
        FUNCT         // Take the operation from funct3 and bit 30
    } alu_class_e;

    // Source of ALU operand A
    typedef enum logic [1:0] {
        PC   = 2'd0,   // auipc
        ZERO = 2'd1,   // lui
        RS1  = 2'd2
    } opa_sel_e;

endpackage

// File: verilog/ctrl_if.sv
`timescale 1ns/100ps

interface ctrl_if;
    import core_pkg::*;

    logic       branch;
    logic       mem_to_reg;   // Write back load data instead of the ALU result
    logic       mem_write;
    logic       alu_src;      // Operand B from the immediate
    logic       reg_write;
    alu_class_e alu_class;
    opa_sel_e   opa_sel;

    modport decoder (
        output branch, mem_to_reg, mem_write, alu_src, reg_write, alu_class, opa_sel
    );

    modport datapath (
        input branch, mem_to_reg, mem_write, alu_src, reg_write, alu_class, opa_sel
    );

endinterface

// File: verilog/control_unit.sv
`timescale 1ns/100ps

module control_unit (
    input  rv_isa_pkg::opcode_e opcode,
    ctrl_if.decoder             ctrl
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    always_comb begin
        // Inactive bundle, kept for any opcode not listed below
        ctrl.branch     = 1'b0;
        ctrl.mem_to_reg = 1'b0;
        ctrl.mem_write  = 1'b0;
        ctrl.alu_src    = 1'b0;
        ctrl.reg_write  = 1'b0;
        ctrl.alu_class  = MEM_ADD;
        ctrl.opa_sel    = RS1;

        case (opcode)
            OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_class = FUNCT;   // alu_src stays low so bit 30 can mean sub
            end
            OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_class = FUNCT;
            end
            LOAD: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_src    = 1'b1;   // rs1 + offset
            end
            STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            BRANCH: begin
                ctrl.branch    = 1'b1;
                ctrl.alu_class = BRANCH_SUB;   // Zero flag means equal
            end
            LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.opa_sel   = ZERO;   // 0 + upper immediate
            end
            AUIPC: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.opa_sel   = PC;
            end
            default: ;
        endcase
    end

endmodule

// File: verilog/alu_control.sv
`timescale 1ns/100ps

module alu_control (
    ctrl_if.datapath          ctrl,
    input  logic [2:0]        funct3,
    input  logic              bit30,
    output core_pkg::alu_op_e alu_op
);
    import core_pkg::*;
    import rv_isa_pkg::*;

    always_comb begin
        case (ctrl.alu_class)
            MEM_ADD:    alu_op = ADD;
            BRANCH_SUB: alu_op = SUB;
            FUNCT: begin
                case (funct3)
                    // addi has no subtract form, bit 30 is part of its immediate
                    F3_ADD_SUB: alu_op = (bit30 && !ctrl.alu_src) ? SUB : ADD;
                    F3_SLL:     alu_op = SLL;
                    F3_SLT:     alu_op = SLT;
                    F3_XOR:     alu_op = XOR;
                    F3_SRL_SRA: alu_op = bit30 ? SRA : SRL;   // Same for OP and OP_IMM
                    F3_OR:      alu_op = OR;
                    F3_AND:     alu_op = AND;
                    default:    alu_op = ADD;   // sltu is not supported
                endcase
            end
            default:    alu_op = ADD;
        endcase
    end

endmodule

// File: verilog/register_file.sv
`timescale 1ns/100ps

module register_file (
    input  logic                               CLK,
    input  logic                               RESET_N,
    ctrl_if.datapath                           ctrl,
    input  logic [core_pkg::REG_ADDR_WIDTH-1:0] rs1_addr,
    input  logic [core_pkg::REG_ADDR_WIDTH-1:0] rs2_addr,
    input  logic [core_pkg::REG_ADDR_WIDTH-1:0] rd_addr,
    input  logic [core_pkg::XLEN-1:0]           alu_result,
    input  logic [core_pkg::XLEN-1:0]           load_data,
    output logic [core_pkg::XLEN-1:0]           rs1_data,
    output logic [core_pkg::XLEN-1:0]           rs2_data
);
    import core_pkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_WIDTH];
    logic [XLEN-1:0] wr_data;

    assign wr_data = ctrl.mem_to_reg ? load_data : alu_result;

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 0; i < 2**REG_ADDR_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.reg_write && rd_addr != '0) begin   // x0 drops writes
            regs[rd_addr] <= wr_data;
        end
    end

    // Asynchronous reads, x0 forced to zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: verilog/imm_gen.sv
`timescale 1ns/100ps

module imm_gen (
    input  logic [core_pkg::XLEN-1:0] instr,
    output logic [core_pkg::XLEN-1:0] imm
);
    import core_pkg::*;
    import rv_isa_pkg::*;

    opcode_e opcode;
    logic    sign;

    assign opcode = opcode_e'(instr[OPCODE_MSB:0]);
    assign sign   = instr[XLEN-1];

    always_comb begin
        case (opcode)
            // I format
            OP_IMM, LOAD: imm = {{20{sign}}, instr[XLEN-1:RS2_LSB]};
            // S format, offset split around rs2
            STORE:        imm = {{20{sign}}, instr[XLEN-1:25], instr[RD_LSB +: 5]};
            // B format, bit 0 is always zero
            BRANCH: begin
                imm = {{19{sign}}, sign, instr[RD_LSB], instr[BIT30_POS:25],
                       instr[11:8], 1'b0};
            end
            // U format
            LUI, AUIPC:   imm = {instr[XLEN-1:FUNCT3_LSB], 12'b0};
            default:      imm = '0;   // R format has no immediate
        endcase
    end

endmodule

// File: verilog/execute_unit.sv
`timescale 1ns/100ps

module execute_unit (
    ctrl_if.datapath                       ctrl,
    input  core_pkg::alu_op_e              alu_op,
    input  logic [core_pkg::ADDR_WIDTH-1:0] pc,
    input  logic [core_pkg::XLEN-1:0]       rs1_data,
    input  logic [core_pkg::XLEN-1:0]       rs2_data,
    input  logic [core_pkg::XLEN-1:0]       imm,
    output logic [core_pkg::XLEN-1:0]       result,
    output logic                           zero
);
    import core_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;

    // --------------------
    // Operand selection
    // --------------------
    always_comb begin
        case (ctrl.opa_sel)
            PC:      op_a = {{(XLEN-ADDR_WIDTH){1'b0}}, pc};
            ZERO:    op_a = '0;
            default: op_a = rs1_data;
        endcase
    end

    assign op_b  = ctrl.alu_src ? imm : rs2_data;
    assign shamt = op_b[4:0];   // Upper bits of a shift amount are ignored

    // --------------------
    // ALU
    // --------------------
    always_comb begin
        case (alu_op)
            ADD:     result = op_a + op_b;
            SUB:     result = op_a - op_b;
            AND:     result = op_a & op_b;
            OR:      result = op_a | op_b;
            XOR:     result = op_a ^ op_b;
            SLT:     result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            SLL:     result = op_a << shamt;
            SRL:     result = op_a >> shamt;
            SRA:     result = $unsigned($signed(op_a) >>> shamt);
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);   // beq compares through SUB

endmodule

// File: verilog/pc_unit.sv
`timescale 1ns/100ps

module pc_unit (
    input  logic                           CLK,
    input  logic                           RESET_N,
    ctrl_if.datapath                       ctrl,
    input  logic                           zero,
    input  logic [core_pkg::XLEN-1:0]       imm,
    output logic [core_pkg::ADDR_WIDTH-1:0] pc
);
    import core_pkg::*;

    logic [ADDR_WIDTH-1:0] pc_seq;
    logic [ADDR_WIDTH-1:0] pc_target;
    logic                  take_branch;

    assign pc_seq      = pc + ADDR_WIDTH'(4);
    assign pc_target   = pc + imm[ADDR_WIDTH-1:0];   // Wraps inside the ROM space
    assign take_branch = ctrl.branch & zero;

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= '0;
        end else begin
            pc <= take_branch ? pc_target : pc_seq;
        end
    end

endmodule

// File: verilog/core_top.sv
`timescale 1ns/100ps

module core_top (
    input  logic                           CLK,
    input  logic                           RESET_N,
    input  logic [core_pkg::XLEN-1:0]       Q_ROM,
    output logic [core_pkg::ADDR_WIDTH-1:0] ADDR_ROM,
    output logic [core_pkg::ADDR_WIDTH-1:0] ADDR_RAM,
    input  logic [core_pkg::XLEN-1:0]       Q_RAM,
    output logic [core_pkg::XLEN-1:0]       Q_W,
    output logic                           ENABLE_W
);
    import core_pkg::*;
    import rv_isa_pkg::*;

    opcode_e                   opcode;
    alu_op_e                   alu_op;
    logic [ADDR_WIDTH-1:0]     pc;
    logic [XLEN-1:0]           rs1_data;
    logic [XLEN-1:0]           rs2_data;
    logic [XLEN-1:0]           imm;
    logic [XLEN-1:0]           alu_result;
    logic                      zero;

    ctrl_if ctrl ();

    // --------------------
    // Decode
    // --------------------
    assign opcode = opcode_e'(Q_ROM[OPCODE_MSB:0]);

    control_unit u_control (
        .opcode (opcode),
        .ctrl   (ctrl.decoder)
    );

    alu_control u_alu_control (
        .ctrl   (ctrl.datapath),
        .funct3 (Q_ROM[FUNCT3_LSB +: 3]),
        .bit30  (Q_ROM[BIT30_POS]),
        .alu_op (alu_op)
    );

    imm_gen u_imm_gen (
        .instr (Q_ROM),
        .imm   (imm)
    );

    // --------------------
    // Datapath
    // --------------------
    register_file u_regs (
        .CLK        (CLK),
        .RESET_N    (RESET_N),
        .ctrl       (ctrl.datapath),
        .rs1_addr   (Q_ROM[RS1_LSB +: REG_ADDR_WIDTH]),
        .rs2_addr   (Q_ROM[RS2_LSB +: REG_ADDR_WIDTH]),
        .rd_addr    (Q_ROM[RD_LSB +: REG_ADDR_WIDTH]),
        .alu_result (alu_result),
        .load_data  (Q_RAM),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data)
    );

    execute_unit u_execute (
        .ctrl     (ctrl.datapath),
        .alu_op   (alu_op),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (imm),
        .result   (alu_result),
        .zero     (zero)
    );

    pc_unit u_pc (
        .CLK     (CLK),
        .RESET_N (RESET_N),
        .ctrl    (ctrl.datapath),
        .zero    (zero),
        .imm     (imm),
        .pc      (pc)
    );

    // Memory ports, all combinational from the current instruction
    assign ADDR_ROM = pc;
    assign ADDR_RAM = alu_result[ADDR_WIDTH-1:0];
    assign Q_W      = rs2_data;
    assign ENABLE_W = ctrl.mem_write;

endmodule

// File: testbench/core_properties.sv
`timescale 1ns/100ps

module core_properties (
    input logic                            CLK,
    input logic                            RESET_N,
    input logic [core_pkg::ADDR_WIDTH-1:0] addr_rom,
    input logic                            enable_w
);

    int fail_count = 0;   // Assertion failures so far

    // --------------------
    // Instruction address
    // --------------------
    property rom_zero_in_reset;
        @(posedge CLK) !RESET_N |-> (addr_rom == '0);
    endproperty

    property rom_word_aligned;
        @(posedge CLK) addr_rom[1:0] == 2'b00;   // Only word steps and even branch offsets
    endproperty

    // --------------------
    // Store strobe
    // --------------------
    property enable_known;
        @(posedge CLK) disable iff (!RESET_N) !$isunknown(enable_w);
    endproperty

    a_rom_reset: assert property (rom_zero_in_reset) else begin
        fail_count++;
        $error("ADDR_ROM not zero in reset");
    end

    a_rom_aligned: assert property (rom_word_aligned) else begin
        fail_count++;
        $error("ADDR_ROM not word aligned");
    end

    a_enable_w: assert property (enable_known) else begin
        fail_count++;
        $error("ENABLE_W is unknown");
    end

endmodule

// File: testbench/tb_core_top.sv
`timescale 1ns/100ps

module tb_core_top;
    import core_pkg::*;
    import rv_isa_pkg::*;

    localparam int RESET_CYCLES   = 8;
    localparam int MEM_WORDS      = 2**(ADDR_WIDTH-2);
    localparam int PROGRAM_CYCLES = 7 + 41 + 8 + 7 + 5 + 241;   // Six programs, halt included
    localparam int TIMEOUT_CYCLES = 2 * (PROGRAM_CYCLES + 6 * (RESET_CYCLES + 2));

    logic                  CLK     = 1'b1;   // First edge falls, so reset lands before a rising edge
    logic                  RESET_N = 1'b1;
    logic [XLEN-1:0]       q_rom   = '0;
    logic [ADDR_WIDTH-1:0] addr_rom;
    logic [ADDR_WIDTH-1:0] addr_ram;
    logic [XLEN-1:0]       q_ram;
    logic [XLEN-1:0]       q_w;
    logic                  enable_w;

    logic [XLEN-1:0]       rom [MEM_WORDS];
    logic [XLEN-1:0]       ram [MEM_WORDS];
    logic [ADDR_WIDTH-1:0] log_addr [$];   // Every store the core made
    logic [XLEN-1:0]       log_data [$];
    logic [ADDR_WIDTH-1:0] exp_addr [$];
    logic [XLEN-1:0]       exp_data [$];
    logic [ADDR_WIDTH-1:0] pc_trace [$];
    logic [ADDR_WIDTH-1:0] exp_trace [$];
    logic [31:0]           rng_state = 32'd79;
    int                    pc_idx;
    int                    errors;
    int                    total_errors = 0;
    int                    tests_run = 0;
    int                    tests_passed = 0;
    int                    cycle_count = 0;

    core_top UUT (
        .CLK      (CLK),
        .RESET_N  (RESET_N),
        .Q_ROM    (q_rom),
        .ADDR_ROM (addr_rom),
        .ADDR_RAM (addr_ram),
        .Q_RAM    (q_ram),
        .Q_W      (q_w),
        .ENABLE_W (enable_w)
    );

    bind core_top core_properties u_props (
        .CLK      (CLK),
        .RESET_N  (RESET_N),
        .addr_rom (ADDR_ROM),
        .enable_w (ENABLE_W)
    );

    always #50 CLK = ~CLK;

    // --------------------
    // Memory models
    // --------------------
    always @(negedge CLK) q_rom <= rom[addr_rom[ADDR_WIDTH-1:2]];

    assign q_ram = ram[addr_ram[ADDR_WIDTH-1:2]];   // Same-cycle read for lw

    always @(posedge CLK) begin
        if (RESET_N && enable_w) begin
            ram[addr_ram[ADDR_WIDTH-1:2]] <= q_w;
            log_addr.push_back(addr_ram);
            log_data.push_back(q_w);
        end
    end

    always @(posedge CLK) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // --------------------
    // Encoders and reference
    // --------------------
    function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic alt,
                                          input logic [4:0] rd, rs1, rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic logic [31:0] enc_i(input opcode_e op, input logic [2:0] f3,
                                          input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [4:0] rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};   // sw, word width
    endfunction

    function automatic logic [31:0] enc_b(input logic [4:0] rs1, rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, F3_ADD_SUB, off[4:1], off[11], BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(input opcode_e op, input logic [4:0] rd,
                                          input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // RV32I integer semantics, alt is instruction bit 30
    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, b);
        logic signed [31:0] sa;
        logic signed [31:0] sr;
        sa = a;
        sr = sa >>> b[4:0];
        case (f3)
            F3_ADD_SUB: return alt ? a - b : a + b;
            F3_SLL:     return a << b[4:0];
            F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_XOR:     return a ^ b;
            F3_SRL_SRA: return alt ? sr : a >> b[4:0];
            F3_OR:      return a | b;
            default:    return a & b;
        endcase
    endfunction

    // --------------------
    // Program helpers
    // --------------------
    task automatic emit(input logic [31:0] instr);
        rom[pc_idx] = instr;
        pc_idx++;
    endtask

    task automatic expect_store(input logic [ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic store_expect(input logic [4:0] rs2, input int addr, input logic [31:0] data);
        emit(enc_s(rs2, 5'd0, 12'(addr)));
        expect_store(ADDR_WIDTH'(addr), data);
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;   // addi sign-extends its low twelve bits
        emit(enc_u(LUI, rd, upper[31:12]));
        emit(enc_i(OP_IMM, F3_ADD_SUB, rd, rd, value[11:0]));
    endtask

    task automatic start_program();
        @(negedge CLK);
        RESET_N = 1'b0;
        pc_idx  = 0;
        errors  = 0;
        exp_addr.delete();
        exp_data.delete();
        exp_trace.delete();
    endtask

    // Appends a self-loop as halt and runs the program until the PC reaches it
    task automatic run_program();
        logic [ADDR_WIDTH-1:0] halt_addr;
        int                    n;
        emit(enc_b(5'd0, 5'd0, 13'd0));
        halt_addr = ADDR_WIDTH'(4 * (pc_idx - 1));
        repeat (RESET_CYCLES) begin
            @(negedge CLK);
            if (addr_rom !== '0) begin
                $display("FAIL ADDR_ROM in reset expected %h got %h", 10'h0, addr_rom);
                errors++;
            end
        end
        log_addr.delete();
        log_data.delete();
        pc_trace.delete();
        RESET_N = 1'b1;
        pc_trace.push_back(addr_rom);
        n = 0;
        while (addr_rom !== halt_addr && n < pc_idx + 4) begin
            @(negedge CLK);
            pc_trace.push_back(addr_rom);
            n++;
        end
        if (addr_rom !== halt_addr) begin
            $display("Program did not reach its halt instruction at %h", halt_addr);
            errors++;
        end
    endtask

    task automatic check_stores();
        if (log_addr.size() != exp_addr.size()) begin
            $display("Expected %0d stores but the core made %0d", exp_addr.size(),
                     log_addr.size());
            errors++;
        end
        for (int i = 0; i < exp_addr.size() && i < log_addr.size(); i++) begin
            if (log_addr[i] !== exp_addr[i]) begin
                $display("FAIL ADDR_RAM store %0d expected %h got %h", i, exp_addr[i],
                         log_addr[i]);
                errors++;
            end
            if (log_data[i] !== exp_data[i]) begin
                $display("FAIL Q_W store %0d expected %h got %h", i, exp_data[i], log_data[i]);
                errors++;
            end
        end
    endtask

    task automatic check_trace();
        if (pc_trace.size() != exp_trace.size()) begin
            $display("PC trace has %0d steps, expected %0d", pc_trace.size(), exp_trace.size());
            errors++;
        end
        for (int i = 0; i < exp_trace.size() && i < pc_trace.size(); i++) begin
            if (pc_trace[i] !== exp_trace[i]) begin
                $display("FAIL ADDR_ROM step %0d expected %h got %h", i, exp_trace[i],
                         pc_trace[i]);
                errors++;
            end
        end
    endtask

    task automatic finish_test(input string name);
        check_stores();
        tests_run++;
        total_errors += errors;
        if (errors == 0) begin
            tests_passed++;
            $display("%s: passed", name);
        end else begin
            $display("%s: %0d errors", name, errors);
        end
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic test_reset_sequence();
        logic [31:0] v;
        start_program();
        v = '0;
        for (int i = 1; i <= 5; i++) begin   // Chain x1..x5 through addi
            emit(enc_i(OP_IMM, F3_ADD_SUB, 5'(i), 5'(i - 1), 12'(3 * i)));
            v = ref_alu(F3_ADD_SUB, 1'b0, v, 32'(3 * i));
        end
        store_expect(5'd5, 32'h20, v);
        run_program();
        for (int i = 0; i < pc_idx; i++) exp_trace.push_back(ADDR_WIDTH'(4 * i));
        check_trace();
        finish_test("reset_sequence");
    endtask

    task automatic test_alu_ops();
        logic [2:0]  r_f3 [9];
        logic        r_alt [9];
        logic [2:0]  i_f3 [8];
        logic [11:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        int          addr;
        r_f3  = '{F3_ADD_SUB, F3_ADD_SUB, F3_AND, F3_OR, F3_XOR, F3_SLT, F3_SLL,
                  F3_SRL_SRA, F3_SRL_SRA};
        r_alt = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
        i_f3  = '{F3_ADD_SUB, F3_AND, F3_OR, F3_XOR, F3_SLT, F3_SLL, F3_SRL_SRA, F3_SRL_SRA};
        a     = 32'h8765_4321;   // Negative, so slt and sra see the sign
        b     = 32'h0000_0A13;
        addr  = 0;
        start_program();
        load_const(5'd1, a);
        load_const(5'd2, b);
        for (int i = 0; i < 9; i++) begin
            emit(enc_r(r_f3[i], r_alt[i], 5'd10, 5'd1, 5'd2));
            store_expect(5'd10, addr, ref_alu(r_f3[i], r_alt[i], a, b));
            addr += 4;
        end
        for (int i = 0; i < 8; i++) begin
            imm = (i < 5) ? 12'hAAA : {(i == 7) ? 7'b0100000 : 7'b0, 5'd7};
            emit(enc_i(OP_IMM, i_f3[i], 5'd10, 5'd1, imm));
            store_expect(5'd10, addr, ref_alu(i_f3[i], i == 7, a, (i < 5) ? sext12(imm) : 32'd7));
            addr += 4;
        end
        emit(enc_i(OP_IMM, F3_ADD_SUB, 5'd0, 5'd0, 12'd77));   // x0 must stay zero
        store_expect(5'd0, addr, 32'd0);
        run_program();
        finish_test("alu_ops");
    endtask

    task automatic test_load_store();
        logic [31:0] val;
        val = 32'h1357_9BDF;
        start_program();
        load_const(5'd5, val);
        emit(enc_i(OP_IMM, F3_ADD_SUB, 5'd7, 5'd0, 12'h030));
        emit(enc_s(5'd5, 5'd7, 12'h010));   // Base register plus offset gives 0x40
        expect_store(10'h040, val);
        emit(enc_i(LOAD, 3'b010, 5'd6, 5'd0, 12'h040));
        emit(enc_i(OP_IMM, F3_ADD_SUB, 5'd6, 5'd6, 12'd1));
        store_expect(5'd6, 32'h44, val + 32'd1);
        run_program();
        finish_test("load_store");
    endtask

    task automatic test_branch();
        start_program();
        emit(enc_i(OP_IMM, F3_ADD_SUB, 5'd1, 5'd0, 12'd9));
        emit(enc_i(OP_IMM, F3_ADD_SUB, 5'd2, 5'd0, 12'd9));
        emit(enc_b(5'd1, 5'd2, 13'd8));    // Equal, jumps over the next store
        emit(enc_s(5'd1, 5'd0, 12'h080));
        emit(enc_b(5'd1, 5'd0, 13'd8));    // Not equal, falls through
        store_expect(5'd2, 32'h84, 32'd9);
        run_program();
        exp_trace = '{10'd0, 10'd4, 10'd8, 10'd16, 10'd20, 10'd24};
        check_trace();
        foreach (log_addr[i]) begin
            if (log_addr[i] === 10'h080) begin
                $display("Store behind the taken branch was executed");
                errors++;
            end
        end
        finish_test("branch_beq");
    endtask

    task automatic test_upper_imm();
        start_program();
        emit(enc_u(LUI, 5'd1, 20'hABCDE));
        store_expect(5'd1, 32'h90, {20'hABCDE, 12'h000});
        emit(enc_u(AUIPC, 5'd2, 20'h00012));   // Sits at PC 8
        store_expect(5'd2, 32'h94, {20'h00012, 12'h000} + 32'd8);
        run_program();
        finish_test("upper_imm");
    endtask

    task automatic test_random_alu();
        logic [2:0]  f3 [5];
        logic        alt [5];
        logic [31:0] a;
        logic [31:0] b;
        f3  = '{F3_ADD_SUB, F3_ADD_SUB, F3_XOR, F3_SLT, F3_SRL_SRA};
        alt = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b1};
        start_program();
        for (int k = 0; k < 40; k++) begin
            rng_state = xorshift32(rng_state);
            a         = rng_state;
            rng_state = xorshift32(rng_state);
            b         = rng_state;
            load_const(5'd1, a);
            load_const(5'd2, b);
            emit(enc_r(f3[k % 5], alt[k % 5], 5'd3, 5'd1, 5'd2));
            store_expect(5'd3, 32'h100 + 4 * k, ref_alu(f3[k % 5], alt[k % 5], a, b));
        end
        run_program();
        finish_test("random_alu");
    endtask

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) ram[i] = 32'hC0DE_0000 | i;
        test_reset_sequence();
        test_alu_ops();
        test_load_store();
        test_branch();
        test_upper_imm();
        test_random_alu();
        if (UUT.u_props.fail_count != 0) begin
            $display("Bound assertions failed %0d times", UUT.u_props.fail_count);
        end
        total_errors += UUT.u_props.fail_count;
        $display("Tests run %0d, passed %0d, failed %0d, errors %0d", tests_run,
                 tests_passed, tests_run - tests_passed, total_errors);
        if (total_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: project.f
verilog/rv_isa_pkg.sv
verilog/core_pkg.sv
verilog/ctrl_if.sv
verilog/control_unit.sv
verilog/alu_control.sv
verilog/register_file.sv
verilog/imm_gen.sv
verilog/execute_unit.sv
verilog/pc_unit.sv
verilog/core_top.sv
testbench/core_properties.sv
testbench/tb_core_top.sv
